// File: design/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_addr_t;

  localparam int lane_count = 2;

  // base opcodes of RV32I
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef struct packed {
    logic valid;
    addr_t pc;                       // address of lane 0
    logic [63:0] data;               // lane 0 in the low word
  } fetch_packet_t;

  typedef struct packed {
    addr_t pc;
    addr_t npc;
    word_t instr;
    logic misaligned;
  } lane_in_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic csreg;
    logic ecall;
    logic ebreak;
    logic mret;
    logic legal;
  } lane_op_t;

  typedef struct packed {
    addr_t pc;
    addr_t npc;
    word_t instr;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t imm;
    lane_op_t op;
    logic valid;
    logic exception;
  } lane_decode_t;

  typedef struct packed {
    lane_decode_t [lane_count-1:0] lane;
    logic valid;
  } decode_packet_t;

  localparam lane_decode_t empty_lane = '0;

endpackage

`default_nettype wire

// File: design/fetch_split.sv
`default_nettype none

module fetch_split import decode_pkg::*; (
  input fetch_packet_t fetch,
  output lane_in_t [lane_count-1:0] lanes
);

  logic misaligned;

  // a packet must start on a word boundary, otherwise every lane traps
  assign misaligned = |fetch.pc[1:0];

  always_comb begin
    addr_t lane_pc;
    lane_pc = fetch.pc;
    for (int i = 0; i < lane_count; i++) begin
      lanes[i].pc = lane_pc;
      lanes[i].npc = lane_pc + 32'd4;
      lanes[i].instr = fetch.valid ? fetch.data[32*i +: 32] : '0;
      lanes[i].misaligned = misaligned;
      lane_pc = lane_pc + 32'd4;  // next lane sits one word higher
    end
  end

endmodule

`default_nettype wire

// File: design/lane_decoder.sv
`default_nettype none

module lane_decoder import decode_pkg::*; (
  input lane_in_t lane,
  output lane_decode_t decoded
);

  word_t instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign instr = lane.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    lane_op_t op;
    word_t imm;
    logic word_ok;
    logic writes;
    op = '0;
    imm = '0;
    word_ok = 1'b0;
    writes = 1'b0;
    case (opcode)
      op_lui, op_auipc: begin
        word_ok = 1'b1;
        op.lui = (opcode == op_lui);
        op.auipc = (opcode == op_auipc);
        writes = 1'b1;
        imm = imm_u;
      end
      op_jal: begin
        word_ok = 1'b1;
        op.jal = 1'b1;
        writes = 1'b1;
        imm = imm_j;
      end
      op_jalr: begin
        word_ok = (funct3 == 3'b000);
        op.jalr = word_ok;
        writes = word_ok;
        op.rden1 = word_ok;
        imm = imm_i;
      end
      op_branch: begin
        word_ok = (funct3[2:1] != 2'b01);  // 010 and 011 are unused
        op.branch = word_ok;
        op.rden1 = word_ok;
        op.rden2 = word_ok;
        imm = imm_b;
      end
      op_load: begin
        word_ok = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        op.load = word_ok;
        writes = word_ok;
        op.rden1 = word_ok;
        imm = imm_i;
      end
      op_store: begin
        word_ok = !funct3[2] && (funct3[1:0] != 2'b11);
        op.store = word_ok;
        op.rden1 = word_ok;
        op.rden2 = word_ok;
        imm = imm_s;
      end
      op_imm: begin
        // shifts keep funct7 in the upper immediate bits
        case (funct3)
          3'b001: word_ok = (funct7 == 7'b0000000);
          3'b101: word_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: word_ok = 1'b1;
        endcase
        op.alu = word_ok;
        writes = word_ok;
        op.rden1 = word_ok;
        imm = imm_i;
      end
      op_reg: begin
        word_ok = (funct7 == 7'b0000000) ||
                  ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
        op.alu = word_ok;
        writes = word_ok;
        op.rden1 = word_ok;
        op.rden2 = word_ok;
      end
      op_fence: begin
        word_ok = (funct3 == 3'b000);
        op.fence = word_ok;
      end
      op_system: begin
        if (funct3 == 3'b000) begin
          op.ecall = (instr == 32'h00000073);
          op.ebreak = (instr == 32'h00100073);
          op.mret = (instr == 32'h30200073);
          word_ok = op.ecall | op.ebreak | op.mret;
        end else if (funct3 != 3'b100) begin
          word_ok = 1'b1;
          op.csreg = 1'b1;
          writes = 1'b1;
          op.rden1 = !funct3[2];  // immediate forms take rs1 as a constant
          imm = imm_i;
        end
      end
      default: word_ok = 1'b0;
    endcase
    op.wren = writes && (instr[11:7] != 5'd0);  // x0 is never written
    op.legal = word_ok && !lane.misaligned;

    decoded.pc = lane.pc;
    decoded.npc = lane.npc;
    decoded.instr = instr;
    decoded.waddr = instr[11:7];
    decoded.raddr1 = instr[19:15];
    decoded.raddr2 = instr[24:20];
    decoded.imm = imm;
    decoded.op = op;
    decoded.valid = 1'b0;
    decoded.exception = 1'b0;
  end

endmodule

`default_nettype wire

// File: design/decode_register.sv
`default_nettype none

module decode_register import decode_pkg::*; (
  input logic clock,
  input logic reset,
  input lane_decode_t [lane_count-1:0] lanes,
  input logic fetch_valid,
  input logic flush,
  input logic halt,
  output decode_packet_t decode
);

  decode_packet_t next;
  logic [lane_count-1:0] lane_valid;
  logic [lane_count-1:0] lane_exception;

  always_comb begin
    next.valid = fetch_valid;
    for (int i = 0; i < lane_count; i++) begin
      next.lane[i] = lanes[i];
      if (fetch_valid) begin
        // an undecodable word still travels on, flagged for the trap logic
        next.lane[i].valid = 1'b1;
        next.lane[i].exception = !lanes[i].op.legal;
      end
    end
    if (flush || halt) begin
      next.valid = 1'b0;
      for (int i = 0; i < lane_count; i++) begin
        next.lane[i] = empty_lane;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      decode <= '0;
    end else begin
      decode <= next;
    end
  end

  always_comb begin
    for (int i = 0; i < lane_count; i++) begin
      lane_valid[i] = decode.lane[i].valid;
      lane_exception[i] = decode.lane[i].exception;
    end
  end

  valid_packet_has_valid_lanes: assert property (@(posedge clock) disable iff (!reset)
    decode.valid |-> &lane_valid);

  flush_drops_next_packet: assert property (@(posedge clock) disable iff (!reset)
    flush |=> !decode.valid);

  exception_only_on_valid_lane: assert property (@(posedge clock) disable iff (!reset)
    (lane_exception & ~lane_valid) == '0);

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none

module decode_stage import decode_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_packet_t fetch,
  input logic flush,
  input logic halt,
  output decode_packet_t decode
);

  lane_in_t [lane_count-1:0] lane_in;
  lane_decode_t [lane_count-1:0] lane_out;

  fetch_split split (
    .fetch(fetch),
    .lanes(lane_in)
  );

  for (genvar i = 0; i < lane_count; i++) begin : g_lane
    lane_decoder decoder (
      .lane(lane_in[i]),
      .decoded(lane_out[i])
    );
  end

  // one register stage holds both lanes for the issue logic
  decode_register decode_reg (
    .clock(clock),
    .reset(reset),
    .lanes(lane_out),
    .fetch_valid(fetch.valid),
    .flush(flush),
    .halt(halt),
    .decode(decode)
  );

endmodule

`default_nettype wire

// File: tests/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// steps a 16-bit Galois LFSR whose low bit is handed out before each step
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  logic [15:0] s;
  s = state >> 1;
  if (state[0]) s = s ^ 16'hb400;
  return s;
endfunction

// builds the sign-extended immediate for a format letter and gives zero when there is none
function automatic word_t build_imm(input word_t w, input logic [7:0] fmt);
  case (fmt)
    "I": return {{21{w[31]}}, w[30:20]};
    "S": return {{21{w[31]}}, w[30:25], w[11:7]};
    "B": return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    "U": return {w[31:12], 12'h000};
    "J": return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    default: return 32'h0;
  endcase
endfunction

function automatic lane_decode_t ref_lane(input addr_t pc, input word_t w, input logic misaligned);
  lane_decode_t d;
  logic [2:0] f3;
  logic [6:0] f7;
  logic ok;
  logic [7:0] fmt;
  d = '0;
  f3 = w[14:12];
  f7 = w[31:25];
  ok = 1'b0;
  fmt = "-";
  d.pc = pc;
  d.npc = pc + 32'd4;
  d.instr = w;
  d.waddr = w[11:7];
  d.raddr1 = w[19:15];
  d.raddr2 = w[24:20];
  case (w[6:0])
    op_lui: begin
      ok = 1'b1;
      fmt = "U";
      d.op.lui = 1'b1;
      d.op.wren = 1'b1;
    end
    op_auipc: begin
      ok = 1'b1;
      fmt = "U";
      d.op.auipc = 1'b1;
      d.op.wren = 1'b1;
    end
    op_jal: begin
      ok = 1'b1;
      fmt = "J";
      d.op.jal = 1'b1;
      d.op.wren = 1'b1;
    end
    op_jalr: begin
      ok = (f3 == 3'd0);
      fmt = "I";
      d.op.jalr = 1'b1;
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
    end
    op_branch: begin
      ok = (f3 != 3'd2) && (f3 != 3'd3);
      fmt = "B";
      d.op.branch = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
    end
    op_load: begin
      ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
      fmt = "I";
      d.op.load = 1'b1;
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
    end
    op_store: begin
      ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2);
      fmt = "S";
      d.op.store = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
    end
    op_imm: begin
      if (f3 == 3'd1) ok = (f7 == 7'h00);
      else if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
      else ok = 1'b1;
      fmt = "I";
      d.op.alu = 1'b1;
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
    end
    op_reg: begin
      ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      d.op.alu = 1'b1;
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
    end
    op_fence: begin
      ok = (f3 == 3'd0);
      d.op.fence = 1'b1;
    end
    op_system: begin
      d.op.ecall = (w == 32'h00000073);
      d.op.ebreak = (w == 32'h00100073);
      d.op.mret = (w == 32'h30200073);
      ok = d.op.ecall || d.op.ebreak || d.op.mret;
      if (f3 != 3'd0 && f3 != 3'd4) begin
        ok = 1'b1;
        fmt = "I";
        d.op.csreg = 1'b1;
        d.op.wren = 1'b1;
        d.op.rden1 = (f3 < 3'd4);
      end
    end
    default: ok = 1'b0;
  endcase
  if (!ok) d.op = '0;  // an undecodable word carries no class and no enables
  if (w[11:7] == 5'd0) d.op.wren = 1'b0;
  d.op.legal = ok && !misaligned;
  if (ok) d.imm = build_imm(w, fmt);
  if (!ok && (w[6:0] == op_jalr || w[6:0] == op_load || w[6:0] == op_imm))
    d.imm = build_imm(w, "I");
  if (!ok && w[6:0] == op_branch) d.imm = build_imm(w, "B");
  if (!ok && w[6:0] == op_store) d.imm = build_imm(w, "S");
  return d;
endfunction

// what decode shows one cycle after these inputs were presented
function automatic decode_packet_t ref_packet(input fetch_packet_t f, input logic flush,
                                             input logic halt, input logic was_reset);
  decode_packet_t p;
  word_t w;
  p = '0;
  if (was_reset || flush || halt) return p;
  p.valid = f.valid;
  for (int i = 0; i < lane_count; i++) begin
    w = f.valid ? f.data[32*i +: 32] : 32'h0;
    p.lane[i] = ref_lane(f.pc + 32'(4 * i), w, f.pc[1:0] != 2'b00);
    if (f.valid) begin
      p.lane[i].valid = 1'b1;
      p.lane[i].exception = !p.lane[i].op.legal;
    end
  end
  return p;
endfunction

`endif

// File: tests/decode_tb.sv
`default_nettype none

module decode_tb import decode_pkg::*; ();

  `include "decode_model.svh"

  logic clock;
  logic reset;
  fetch_packet_t fetch;
  logic flush;
  logic halt;
  decode_packet_t decode;

  fetch_packet_t prev_fetch;
  logic prev_flush;
  logic prev_halt;
  logic prev_in_reset;
  decode_packet_t expected;
  logic [15:0] lfsr;
  int errors;
  int cycles;

  decode_stage DUT (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .flush(flush),
    .halt(halt),
    .decode(decode)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    prev_fetch <= fetch;
    prev_flush <= flush;
    prev_halt <= halt;
    prev_in_reset <= !reset;
    if (reset) cycles <= cycles + 1;
  end

  always_comb expected = ref_packet(prev_fetch, prev_flush, prev_halt, prev_in_reset);

  function automatic void report_mismatch(input string name, input logic [31:0] exp_v,
                                          input logic [31:0] act_v);
    errors++;
    $display("MISMATCH time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
  endfunction

  valid_check: assert property (@(posedge clock) disable iff (!reset)
    decode.valid == expected.valid)
    else report_mismatch("decode.valid", 32'($sampled(expected.valid)),
      32'($sampled(decode.valid)));

  for (genvar i = 0; i < lane_count; i++) begin : g_check
    pc_check: assert property (@(posedge clock) disable iff (!reset)
      decode.lane[i].pc == expected.lane[i].pc)
      else report_mismatch($sformatf("decode.lane[%0d].pc", i),
        $sampled(expected.lane[i].pc), $sampled(decode.lane[i].pc));
    npc_check: assert property (@(posedge clock) disable iff (!reset)
      decode.lane[i].npc == expected.lane[i].npc)
      else report_mismatch($sformatf("decode.lane[%0d].npc", i),
        $sampled(expected.lane[i].npc), $sampled(decode.lane[i].npc));
    instr_check: assert property (@(posedge clock) disable iff (!reset)
      decode.lane[i].instr == expected.lane[i].instr)
      else report_mismatch($sformatf("decode.lane[%0d].instr", i),
        $sampled(expected.lane[i].instr), $sampled(decode.lane[i].instr));
    reg_check: assert property (@(posedge clock) disable iff (!reset)
      {decode.lane[i].waddr, decode.lane[i].raddr1, decode.lane[i].raddr2} ==
      {expected.lane[i].waddr, expected.lane[i].raddr1, expected.lane[i].raddr2})
      else report_mismatch($sformatf("decode.lane[%0d] register fields", i),
        32'($sampled({expected.lane[i].waddr, expected.lane[i].raddr1, expected.lane[i].raddr2})),
        32'($sampled({decode.lane[i].waddr, decode.lane[i].raddr1, decode.lane[i].raddr2})));
    imm_check: assert property (@(posedge clock) disable iff (!reset)
      decode.lane[i].imm == expected.lane[i].imm)
      else report_mismatch($sformatf("decode.lane[%0d].imm", i),
        $sampled(expected.lane[i].imm), $sampled(decode.lane[i].imm));
    op_check: assert property (@(posedge clock) disable iff (!reset)
      decode.lane[i].op == expected.lane[i].op)
      else report_mismatch($sformatf("decode.lane[%0d].op", i),
        32'($sampled(expected.lane[i].op)), 32'($sampled(decode.lane[i].op)));
    status_check: assert property (@(posedge clock) disable iff (!reset)
      {decode.lane[i].valid, decode.lane[i].exception} ==
      {expected.lane[i].valid, expected.lane[i].exception})
      else report_mismatch($sformatf("decode.lane[%0d] valid/exception", i),
        32'($sampled({expected.lane[i].valid, expected.lane[i].exception})),
        32'($sampled({decode.lane[i].valid, decode.lane[i].exception})));
  end

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // picks mostly legal words of every format and mixes in some zero and random words
  task automatic make_word(output word_t w);
    logic [31:0] r;
    logic [31:0] k;
    random_bits(32, r);
    random_bits(4, k);
    w = r;
    case (k[3:0])
      4'd0: w[6:0] = op_lui;
      4'd1: w[6:0] = op_auipc;
      4'd2: w[6:0] = op_jal;
      4'd3: begin
        w[6:0] = op_jalr;
        w[14:12] = 3'd0;
      end
      4'd4: begin
        w[6:0] = op_branch;
        if (w[14:13] == 2'b01) w[14] = 1'b1;
      end
      4'd5: begin
        w[6:0] = op_load;
        if (w[14:12] == 3'd3 || w[14:13] == 2'b11) w[14:12] = 3'd2;
      end
      4'd6: begin
        w[6:0] = op_store;
        w[14] = 1'b0;
        if (w[13:12] == 2'b11) w[13:12] = 2'b00;
      end
      4'd7: begin
        w[6:0] = op_imm;
        if (w[14:12] == 3'd1) w[31:25] = 7'h00;
        if (w[14:12] == 3'd5) w[31:25] = {1'b0, r[30], 5'b0};
      end
      4'd8: begin
        w[6:0] = op_reg;
        w[31:25] = (r[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
      end
      4'd9: begin
        w[6:0] = op_fence;
        w[14:12] = 3'd0;
      end
      4'd10: begin
        case (r[17:16])
          2'd0: w = 32'h00000073;
          2'd1: w = 32'h00100073;
          2'd2: w = 32'h30200073;
          default: begin
            w[6:0] = op_system;
            if (w[14:12] == 3'd0 || w[14:12] == 3'd4) w[14:12] = 3'd1;
          end
        endcase
      end
      4'd11: w = 32'h0;
      default: w = r;  // mostly undecodable
    endcase
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] pc_bits;
    word_t lo;
    word_t hi;
    logic seen;
    lfsr = 16'd6;
    errors = 0;
    cycles = 0;
    reset = 1'b0;
    fetch = '0;
    flush = 1'b0;
    halt = 1'b0;
    repeat (2) @(posedge clock);
    #5 reset = 1'b1;
    for (int n = 0; n < 500; n++) begin
      @(posedge clock);
      #5;
      random_bits(8, r);
      random_bits(32, pc_bits);
      make_word(lo);
      make_word(hi);
      fetch.valid = (r[1:0] != 2'b00);
      fetch.pc = pc_bits;
      if (pc_bits[31:29] != 3'b000) fetch.pc[1:0] = 2'b00;  // roughly one packet in eleven misaligned
      fetch.data = {hi, lo};
      flush = (r[4:2] == 3'b000);
      halt = (r[7:5] == 3'b000);
    end
    @(posedge clock);
    #5;
    fetch.valid = 1'b1;
    fetch.pc = 32'h00001000;
    fetch.data = {32'h00100073, 32'h00500093};
    flush = 1'b0;
    halt = 1'b0;
    seen = 1'b0;
    for (int t = 0; t < 8 && !seen; t++) begin
      @(posedge clock);
      #5;
      seen = decode.valid;
      fetch.valid = 1'b0;
    end
    if (!seen) begin
      errors++;
      $display("no decode output arrived within 8 cycles of a fetch");
    end
    repeat (2) @(posedge clock);
    #5;
    $display("checked %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #60000;
    $display("simulation ran past its time limit, %0d errors so far", errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+tests
design/decode_pkg.sv
design/fetch_split.sv
design/lane_decoder.sv
design/decode_register.sv
design/decode_stage.sv
tests/decode_tb.sv

// File: run.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module decode_tb -o decode_sim \
  > build.log 2>&1 &&
./obj_dir/decode_sim > sim.log 2>&1 ||
echo "build or simulation did not complete, see build.log and sim.log"
grep -q "ALL CHECKS PASSED" sim.log && exit 0 || exit 1
